// File: all.f
src/bin_pkg.sv
src/video_if.sv
src/frame_stats.sv
src/binarize_cfg.sv
src/pixel_binarizer.sv
src/binarize_top.sv
sim/binarize_tb.sv

// File: sim/binarize_tb.sv
`timescale 1ns/10ps

module binarize_tb import bin_pkg::*;
();

    localparam int LINE_CYC    = H_ACT + 4;
    localparam int FRAME_CYC   = (V_ACT + 2) * LINE_CYC;
    localparam int NUM_FRAMES  = 8;
    localparam int TIMEOUT_CYC = NUM_FRAMES * FRAME_CYC + 200;

    // Pixel pattern kinds
    localparam logic [1:0] PAT_RANDOM = 2'd0;
    localparam logic [1:0] PAT_FLAT   = 2'd1;
    localparam logic [1:0] PAT_RAMP   = 2'd2;

    typedef struct packed {
        logic       wr_en;
        bin_mode_e  wr_mode;
        logic [3:0] wr_line;
        bin_mode_e  exp_mode;
        logic [1:0] kind;
        logic [7:0] value;
    } frame_row_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic de;
        rgb_t pix;
    } exp_t;

    logic       clk;
    logic       rstn;
    logic       in_hsync;
    logic       in_vsync;
    logic       in_de;
    logic [7:0] in_r;
    logic [7:0] in_g;
    logic [7:0] in_b;
    logic       cfg_valid;
    bin_mode_e  cfg_mode;
    logic       cfg_ready;
    logic       out_hsync;
    logic       out_vsync;
    logic       out_de;
    logic [7:0] out_r;
    logic [7:0] out_g;
    logic [7:0] out_b;

    frame_row_t frames [NUM_FRAMES];
    exp_t       exp_q [$];

    // Reference model state
    int         sum_r;
    int         sum_g;
    int         sum_b;
    rgb_t       thr;
    bin_mode_e  frame_mode;
    logic       model_pending;
    logic       model_vsync_d;
    logic       cfg_want;
    bin_mode_e  want_mode;

    int         errors;
    int         cycles;

    binarize_top dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .in_hsync  (in_hsync),
        .in_vsync  (in_vsync),
        .in_de     (in_de),
        .in_r      (in_r),
        .in_g      (in_g),
        .in_b      (in_b),
        .cfg_valid (cfg_valid),
        .cfg_mode  (cfg_mode),
        .cfg_ready (cfg_ready),
        .out_hsync (out_hsync),
        .out_vsync (out_vsync),
        .out_de    (out_de),
        .out_r     (out_r),
        .out_g     (out_g),
        .out_b     (out_b)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYC);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_pix(input rgb_t exp_pix, input rgb_t act_pix);
        if (exp_pix !== act_pix) begin
            errors++;
            $display("[FAIL] out_r/out_g/out_b expected %06h got %06h at %0t",
                     exp_pix, act_pix, $time);
            abort_run();
        end
    endtask

    task automatic check_sync(input logic [2:0] exp_sync, input logic [2:0] act_sync);
        if (exp_sync !== act_sync) begin
            errors++;
            $display("[FAIL] out_hsync/out_vsync/out_de expected %01h got %01h at %0t",
                     exp_sync, act_sync, $time);
            abort_run();
        end
    endtask

    task automatic check_ready(input logic exp_rdy, input logic act_rdy);
        if (exp_rdy !== act_rdy) begin
            errors++;
            $display("[FAIL] cfg_ready expected %01h got %01h at %0t",
                     exp_rdy, act_rdy, $time);
            abort_run();
        end
    endtask

    // Per-channel result as the mode rules define it
    function automatic logic [7:0] expect_chan(
        input logic [7:0] v,
        input logic [7:0] t,
        input bin_mode_e  m
    );
        logic [7:0] level;
        level = (v >= t) ? 8'hff : 8'h00;
        if (m == MODE_BYPASS) begin
            return v;
        end else if (m == MODE_BINARY_INV) begin
            return ~level;
        end
        return level;
    endfunction

    function automatic rgb_t make_pix(input logic [1:0] kind, input logic [7:0] value,
                                      input int x, input int y);
        rgb_t p;
        if (kind == PAT_FLAT) begin
            p = {value, value, value};
        end else if (kind == PAT_RAMP) begin
            p.r = 8'(x * 16);
            p.g = 8'(y * 32);
            p.b = 8'(x * 8 + y * 16);
        end else begin
            // Different ranges give each channel its own mean
            p.r = 8'($urandom_range(0, 255));
            p.g = 8'($urandom_range(0, 127));
            p.b = 8'($urandom_range(128, 255));
        end
        return p;
    endfunction

    task automatic load_table();
        frames[0] = '{1'b0, MODE_BYPASS,     4'd0, MODE_BINARY,     PAT_RANDOM, 8'h00};
        frames[1] = '{1'b0, MODE_BYPASS,     4'd0, MODE_BINARY,     PAT_RANDOM, 8'h00};
        // Write lands mid frame, so the frame stays binarized
        frames[2] = '{1'b1, MODE_BYPASS,     4'd5, MODE_BINARY,     PAT_RAMP,   8'h00};
        frames[3] = '{1'b0, MODE_BYPASS,     4'd0, MODE_BYPASS,     PAT_RANDOM, 8'h00};
        frames[4] = '{1'b1, MODE_BINARY_INV, 4'd4, MODE_BYPASS,     PAT_FLAT,   8'h5a};
        // Second write while the previous one still waits
        frames[5] = '{1'b1, MODE_BINARY,     4'd0, MODE_BINARY_INV, PAT_FLAT,   8'h5a};
        frames[6] = '{1'b0, MODE_BYPASS,     4'd0, MODE_BINARY,     PAT_RANDOM, 8'h00};
        frames[7] = '{1'b0, MODE_BYPASS,     4'd0, MODE_BINARY,     PAT_RAMP,   8'h00};
    endtask

    // One clock of stimulus, plus check of the previous cycle's output
    task automatic step(input logic hs, input logic vs, input logic de, input rgb_t pix);
        exp_t e;
        exp_t prev;
        logic drv_valid;
        logic fend;
        @(posedge clk);
        in_hsync  <= hs;
        in_vsync  <= vs;
        in_de     <= de;
        in_r      <= pix.r;
        in_g      <= pix.g;
        in_b      <= pix.b;
        cfg_valid <= cfg_want;
        cfg_mode  <= want_mode;
        drv_valid = cfg_want;
        @(negedge clk);
        if (exp_q.size() > 0) begin
            prev = exp_q.pop_front();
            check_sync({prev.hs, prev.vs, prev.de}, {out_hsync, out_vsync, out_de});
            check_pix(prev.pix, {out_r, out_g, out_b});
        end
        check_ready(!model_pending, cfg_ready);

        e.hs = hs;
        e.vs = vs;
        e.de = de;
        if (de) begin
            e.pix.r = expect_chan(pix.r, thr.r, frame_mode);
            e.pix.g = expect_chan(pix.g, thr.g, frame_mode);
            e.pix.b = expect_chan(pix.b, thr.b, frame_mode);
            sum_r += pix.r;
            sum_g += pix.g;
            sum_b += pix.b;
        end else begin
            e.pix = pix;
        end
        exp_q.push_back(e);

        // Handshake as the coming edge will see it
        fend = !vs && model_vsync_d;
        if (drv_valid && !model_pending) begin
            model_pending = 1'b1;
            cfg_want = 1'b0;
        end else if (fend && model_pending) begin
            model_pending = 1'b0;
        end
        model_vsync_d = vs;
    endtask

    initial begin
        frame_row_t row;
        rgb_t       pix;
        logic       hs;
        logic       vs;
        logic       de;

        void'($urandom(32'he8d));
        clk       = 1'b0;
        rstn      = 1'b0;
        in_hsync  = 1'b0;
        in_vsync  = 1'b0;
        in_de     = 1'b0;
        in_r      = 8'h00;
        in_g      = 8'h00;
        in_b      = 8'h00;
        cfg_valid = 1'b0;
        cfg_mode  = MODE_BYPASS;
        errors    = 0;
        cycles    = 0;
        sum_r     = 0;
        sum_g     = 0;
        sum_b     = 0;
        thr       = '0;
        cfg_want  = 1'b0;
        want_mode = MODE_BYPASS;
        model_pending = 1'b0;
        model_vsync_d = 1'b0;
        load_table();

        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        // Quiet outputs straight after reset
        check_sync(3'b000, {out_hsync, out_vsync, out_de});
        check_pix('0, {out_r, out_g, out_b});
        check_ready(1'b1, cfg_ready);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            row = frames[f];
            frame_mode = row.exp_mode;
            thr.r = 8'(sum_r >> FRAME_SHIFT);
            thr.g = 8'(sum_g >> FRAME_SHIFT);
            thr.b = 8'(sum_b >> FRAME_SHIFT);
            sum_r = 0;
            sum_g = 0;
            sum_b = 0;
            for (int ln = 0; ln < V_ACT + 2; ln++) begin
                if (row.wr_en && ln == int'(row.wr_line)) begin
                    cfg_want  = 1'b1;
                    want_mode = row.wr_mode;
                end
                for (int x = 0; x < LINE_CYC; x++) begin
                    hs = (x < 4);
                    vs = (ln == 0);
                    de = (ln >= 2) && (x >= 4);
                    if (de) begin
                        pix = make_pix(row.kind, row.value, x - 4, ln - 2);
                    end else begin
                        pix = rgb_t'($urandom);
                    end
                    step(hs, vs, de, pix);
                end
            end
        end
        // Flush the last active pixel through
        step(1'b0, 1'b0, 1'b0, '0);

        if (errors == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule : binarize_tb

// File: src/bin_pkg.sv
package bin_pkg;

    // Active frame geometry
    localparam int H_ACT = 16;
    localparam int V_ACT = 8;

    // Pixel count must be a power of two for the mean to be a plain shift
    localparam int FRAME_SHIFT = $clog2(H_ACT * V_ACT);

    // One 8-bit channel summed over a whole frame
    localparam int SUM_W = 8 + FRAME_SHIFT;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef enum logic [1:0] {
        MODE_BYPASS     = 2'd0,
        // Channel at or above its threshold gives all ones
        MODE_BINARY     = 2'd1,
        MODE_BINARY_INV = 2'd2
    } bin_mode_e;

endpackage : bin_pkg

// File: src/binarize_cfg.sv
`timescale 1ns/10ps

module binarize_cfg import bin_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      cfg_valid,
    input  bin_mode_e cfg_mode,
    output logic      cfg_ready,
    input  logic      frame_end,
    output bin_mode_e mode
);

    bin_mode_e pend_mode;
    logic      pending;
    logic      cfg_accept;
    logic      commit;

    // Only one write may wait for the frame boundary
    assign cfg_ready  = !pending;
    assign cfg_accept = cfg_valid && cfg_ready;

    // A write landing on the boundary cycle waits for the next one
    assign commit = frame_end && pending;

    always_ff @(posedge clk) begin
        if (cfg_accept) begin
            pend_mode <= cfg_mode;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pending <= 1'b0;
        end else if (cfg_accept) begin
            pending <= 1'b1;
        end else if (commit) begin
            pending <= 1'b0;
        end
    end

    // Active mode only changes between frames
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mode <= MODE_BINARY;
        end else if (commit) begin
            mode <= pend_mode;
        end
    end

endmodule : binarize_cfg

// File: src/binarize_top.sv
`timescale 1ns/10ps

module binarize_top import bin_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,

    // Incoming video
    input  logic       in_hsync,
    input  logic       in_vsync,
    input  logic       in_de,
    input  logic [7:0] in_r,
    input  logic [7:0] in_g,
    input  logic [7:0] in_b,

    // Mode write
    input  logic       cfg_valid,
    input  bin_mode_e  cfg_mode,
    output logic       cfg_ready,

    // Filtered video, one cycle behind the input
    output logic       out_hsync,
    output logic       out_vsync,
    output logic       out_de,
    output logic [7:0] out_r,
    output logic [7:0] out_g,
    output logic [7:0] out_b
);

    rgb_t      thresh;
    logic      frame_end;
    bin_mode_e mode;

    video_if vid_in ();
    video_if vid_out ();

    assign vid_in.hsync = in_hsync;
    assign vid_in.vsync = in_vsync;
    assign vid_in.de    = in_de;
    assign vid_in.pix.r = in_r;
    assign vid_in.pix.g = in_g;
    assign vid_in.pix.b = in_b;

    frame_stats stats_i (
        .clk       (clk),
        .rstn      (rstn),
        .vin       (vid_in.snk),
        .thresh    (thresh),
        .frame_end (frame_end)
    );

    binarize_cfg cfg_i (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_valid (cfg_valid),
        .cfg_mode  (cfg_mode),
        .cfg_ready (cfg_ready),
        .frame_end (frame_end),
        .mode      (mode)
    );

    pixel_binarizer bin_i (
        .clk    (clk),
        .rstn   (rstn),
        .vin    (vid_in.snk),
        .vout   (vid_out.src),
        .thresh (thresh),
        .mode   (mode)
    );

    assign out_hsync = vid_out.hsync;
    assign out_vsync = vid_out.vsync;
    assign out_de    = vid_out.de;
    assign out_r     = vid_out.pix.r;
    assign out_g     = vid_out.pix.g;
    assign out_b     = vid_out.pix.b;

endmodule : binarize_top

// File: src/frame_stats.sv
`timescale 1ns/10ps

module frame_stats import bin_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    video_if.snk        vin,
    output rgb_t        thresh,
    output logic        frame_end
);

    logic             vsync_d;
    logic             vsync_rise;
    logic             vsync_fall;

    logic [SUM_W-1:0] r_cur_sum;
    logic [SUM_W-1:0] g_cur_sum;
    logic [SUM_W-1:0] b_cur_sum;
    logic [SUM_W-1:0] r_last_sum;
    logic [SUM_W-1:0] g_last_sum;
    logic [SUM_W-1:0] b_last_sum;

    // Vsync edge detection
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vsync_d <= 1'b0;
        end else begin
            vsync_d <= vin.vsync;
        end
    end

    assign vsync_rise = vin.vsync && !vsync_d;
    assign vsync_fall = !vin.vsync && vsync_d;

    // Frame boundary for the config block
    assign frame_end = vsync_fall;

    // Running sums of the frame in progress
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_cur_sum <= '0;
            g_cur_sum <= '0;
            b_cur_sum <= '0;
        end else if (vsync_rise) begin
            r_cur_sum <= '0;
            g_cur_sum <= '0;
            b_cur_sum <= '0;
        end else if (vin.de) begin
            r_cur_sum <= r_cur_sum + SUM_W'(vin.pix.r);
            g_cur_sum <= g_cur_sum + SUM_W'(vin.pix.g);
            b_cur_sum <= b_cur_sum + SUM_W'(vin.pix.b);
        end
    end

    // Totals of the last complete frame
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_last_sum <= '0;
            g_last_sum <= '0;
            b_last_sum <= '0;
        end else if (vsync_rise) begin
            r_last_sum <= r_cur_sum;
            g_last_sum <= g_cur_sum;
            b_last_sum <= b_cur_sum;
        end
    end

    // Mean per channel, sum divided by the pixel count
    assign thresh.r = r_last_sum[SUM_W-1:FRAME_SHIFT];
    assign thresh.g = g_last_sum[SUM_W-1:FRAME_SHIFT];
    assign thresh.b = b_last_sum[SUM_W-1:FRAME_SHIFT];

endmodule : frame_stats

// File: src/pixel_binarizer.sv
`timescale 1ns/10ps

module pixel_binarizer import bin_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    video_if.snk      vin,
    video_if.src      vout,
    input  rgb_t      thresh,
    input  bin_mode_e mode
);

    rgb_t pix_bin;
    rgb_t pix_next;

    // One channel against its own threshold
    function automatic logic [7:0] bin_chan(
        input logic [7:0] value,
        input logic [7:0] level,
        input bin_mode_e  sel
    );
        logic [7:0] hit;
        logic [7:0] res;
        hit = (value >= level) ? 8'hff : 8'h00;
        case (sel)
            MODE_BINARY:     res = hit;
            MODE_BINARY_INV: res = ~hit;
            default:         res = value;
        endcase
        return res;
    endfunction

    always_comb begin
        pix_bin.r = bin_chan(vin.pix.r, thresh.r, mode);
        pix_bin.g = bin_chan(vin.pix.g, thresh.g, mode);
        pix_bin.b = bin_chan(vin.pix.b, thresh.b, mode);
    end

    // Blanking pixels are left alone
    assign pix_next = vin.de ? pix_bin : vin.pix;

    // Sync and pixel share one stage so the stream stays aligned
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vout.hsync <= 1'b0;
            vout.vsync <= 1'b0;
            vout.de    <= 1'b0;
            vout.pix   <= '0;
        end else begin
            vout.hsync <= vin.hsync;
            vout.vsync <= vin.vsync;
            vout.de    <= vin.de;
            vout.pix   <= pix_next;
        end
    end

endmodule : pixel_binarizer

// File: src/video_if.sv
`timescale 1ns/10ps

interface video_if import bin_pkg::*;
();

    logic hsync;
    logic vsync;
    logic de;
    rgb_t pix;

    // Driving side of the stream
    modport src (
        output hsync,
        output vsync,
        output de,
        output pix
    );

    // Receiving side, possibly more than one per stream
    modport snk (
        input hsync,
        input vsync,
        input de,
        input pix
    );

endinterface : video_if
